// File: common/eth_pkg.sv
`include "eth_settings.svh"

package eth_pkg;

    // One GMII receive sample per clock
    typedef struct packed {
        logic [7:0] data;                       // Receive byte
        logic       dv;                         // Data valid, high for the whole frame
        logic       er;                         // Receive error from the PHY
    } phy_rx_t;

    // End-of-frame verdict from the MAC
    typedef enum logic [2:0] {
        RX_OK       = 3'd0,                     // Frame passed every check
        RX_FCS_ERR  = 3'd1,                     // CRC residue mismatch
        RX_PHY_ERR  = 3'd2,                     // er seen during the frame
        RX_LEN_ERR  = 3'd3,                     // Runt or oversize frame
        RX_OVERFLOW = 3'd4                      // Frame did not fit in the store
    } rx_status_t;

    // MAC to frame FIFO beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;                       // Final non-FCS byte of the frame
        rx_status_t status;                     // Only meaningful with last
    } mac_beat_t;

    // Output stream byte
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } axis_byte_t;

    // Per-cause frame counters, all wrap
    typedef struct packed {
        logic [`ETH_CNT_WIDTH-1:0] frames_ok;
        logic [`ETH_CNT_WIDTH-1:0] frames_fcs_err;
        logic [`ETH_CNT_WIDTH-1:0] frames_phy_err;
        logic [`ETH_CNT_WIDTH-1:0] frames_len_err;
        logic [`ETH_CNT_WIDTH-1:0] frames_overflow;
    } rx_stats_t;

endpackage

// File: common/eth_settings.svh
`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// Frame store size in bytes, must stay a power of two
`define ETH_FIFO_DEPTH 2048

// Legal frame length in bytes, destination address up to and including the FCS
`define ETH_MIN_FRAME 64
`define ETH_MAX_FRAME 1518

// CRC-32 polynomial in LSB-first form
`define ETH_CRC_POLY 32'hEDB88320

// Register value left behind by a good frame plus its own FCS
`define ETH_CRC_RESIDUE 32'hDEBB20E3

// Width of every statistics counter
`define ETH_CNT_WIDTH 16

`endif

// File: filelist.f
+incdir+common
common/eth_pkg.sv
rx_mac/rx_crc32.sv
rx_mac/rx_mac.sv
verilog/rx_frame_fifo.sv
verilog/eth_rx_top.sv
tb/tb_clock.sv
tb/eth_rx_tb.sv

// File: rx_mac/rx_crc32.sv
`timescale 1ns/10ps

`include "eth_settings.svh"

module rx_crc32 (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       clear,                   // Start of a new frame
    input  logic       byte_en,                 // data holds a frame byte
    input  logic [7:0] data,
    output logic       crc_ok                   // Residue reached
);

    logic [31:0] crc_q;                         // Running CRC, LSB-first form

    // Push one byte through the register, bit 0 of the byte goes first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [7:0]  byte_in);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ byte_in[i]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;   // Feedback taps
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            crc_q <= '1;                        // Preset value
        end else if (clear) begin
            crc_q <= '1;                        // Reload at SFD
        end else if (byte_en) begin
            crc_q <= crc_byte(crc_q, data);
        end
    end

    // Data and FCS together leave the fixed residue, no final inversion needed
    assign crc_ok = (crc_q == `ETH_CRC_RESIDUE);

endmodule

// File: rx_mac/rx_mac.sv
`timescale 1ns/10ps

`include "eth_settings.svh"

module rx_mac import eth_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  phy_rx_t   phy_in,                   // GMII receive sample
    output mac_beat_t mac_beat,                 // Frame bytes without preamble and FCS
    output logic      mac_valid
);

    localparam logic [7:0] PRE_BYTE = 8'h55;    // Preamble pattern
    localparam logic [7:0] SFD_BYTE = 8'hD5;    // Start frame delimiter
    localparam int         CNT_W    = 11;       // Enough for the longest legal frame
    localparam logic [CNT_W-1:0] CNT_SAT = '1;  // Counter sticks here on giant frames

    typedef enum logic {
        IDLE,                                   // Hunting for the SFD
        PAYLOAD                                 // Receiving frame bytes
    } state_t;

    state_t           state_q;
    logic [4:0][7:0]  dly_q;                    // [0] newest byte, [4] oldest
    logic [CNT_W-1:0] cnt_q;                    // Bytes seen since the SFD
    logic             er_q;                     // er seen in this frame
    logic             junk_q;                   // Burst without a clean preamble
    logic             sfd_seen;
    logic             frame_byte;
    logic             frame_end;
    logic             crc_ok;
    rx_status_t       end_status;

    // SFD only counts while the burst so far has been pure preamble
    assign sfd_seen   = (state_q == IDLE) && phy_in.dv && !junk_q &&
                        (phy_in.data == SFD_BYTE);
    assign frame_byte = (state_q == PAYLOAD) && phy_in.dv;
    assign frame_end  = (state_q == PAYLOAD) && !phy_in.dv;     // First cycle after the frame

    rx_crc32 u_rx_crc32 (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (sfd_seen),
        .byte_en (frame_byte),
        .data    (phy_in.data),
        .crc_ok  (crc_ok)
    );

    // Verdict, PHY error beats length error beats FCS error
    always_comb begin
        if (er_q) begin
            end_status = RX_PHY_ERR;
        end else if ((cnt_q < `ETH_MIN_FRAME) || (cnt_q > `ETH_MAX_FRAME)) begin
            end_status = RX_LEN_ERR;            // Also covers runts shorter than the FCS
        end else if (!crc_ok) begin
            end_status = RX_FCS_ERR;
        end else begin
            end_status = RX_OK;
        end
    end

    // Control path
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            er_q      <= 1'b0;
            junk_q    <= 1'b0;
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= 1'b0;                  // Single-cycle beats
            case (state_q)
                IDLE: begin
                    if (!phy_in.dv) begin
                        junk_q <= 1'b0;         // Gap rearms the hunt
                    end else if ((phy_in.data != PRE_BYTE) &&
                                 (phy_in.data != SFD_BYTE)) begin
                        junk_q <= 1'b1;         // Ignore the rest of this burst
                    end
                    if (sfd_seen) begin
                        state_q <= PAYLOAD;
                        cnt_q   <= '0;
                        er_q    <= 1'b0;
                    end
                end
                PAYLOAD: begin
                    if (phy_in.dv) begin
                        if (cnt_q != CNT_SAT) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                        if (phy_in.er) begin
                            er_q <= 1'b1;
                        end
                        // Delay line full, oldest byte is clear of the FCS
                        if (cnt_q >= CNT_W'(5)) begin
                            mac_valid <= 1'b1;
                        end
                    end else begin
                        mac_valid <= 1'b1;      // Closing beat with the verdict
                        state_q   <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Data path, the four youngest bytes are the FCS candidate
    always_ff @(posedge clk) begin
        if (frame_byte) begin
            dly_q <= {dly_q[3:0], phy_in.data};
        end
        mac_beat.data   <= dly_q[4];            // Last non-FCS byte when the frame ends
        mac_beat.last   <= frame_end;
        mac_beat.status <= frame_end ? end_status : RX_OK;
    end

endmodule

// File: tb/eth_rx_tb.sv
`timescale 1ns/10ps

`include "eth_settings.svh"

module eth_rx_tb import eth_pkg::*; ();

    localparam int     CLK_PERIOD   = 4;
    localparam int     READY_HIGH   = 0;
    localparam int     READY_RANDOM = 1;
    localparam int     READY_LOW    = 2;
    localparam int     FRAME_CYCLES = 8 + 1530 + 28;        // Preamble, longest body, longest gap
    localparam int     FRAME_BUDGET = 12 + 7 + 6 + 8 + 16 + 40;
    localparam longint WATCHDOG_NS  = longint'(FRAME_BUDGET) * FRAME_CYCLES * 4 * CLK_PERIOD
                                      + 20000;
    localparam int     DRAIN_LIMIT  = 4 * `ETH_FIFO_DEPTH + 200;

    logic       clk;
    logic       reset_n;
    phy_rx_t    phy_in;
    axis_byte_t m_axis;
    logic       m_valid;
    logic       m_ready;
    rx_stats_t  stats;

    logic [15:0] lfsr_q;                        // Shared random state
    int          ready_mode;
    logic [7:0]  frame_q[$];                    // Frame under construction, FCS included
    logic [8:0]  exp_q[$];                      // Expected {data, last} on the output
    logic [8:0]  exp_byte;
    logic        stall_q;                       // Previous edge had valid without ready
    axis_byte_t  held_q;
    int          exp_ok, exp_fcs, exp_phy, exp_len, exp_ovf;
    int          test_errors, total_errors, tests_run, tests_ok;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_tb_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    eth_rx_top dut (
        .clk     (clk),
        .reset_n (reset_n),
        .phy_in  (phy_in),
        .m_axis  (m_axis),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .stats   (stats)
    );

    // 16-bit Galois LFSR with taps for a maximal sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];           // One step per bit taken
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(16) % (hi - lo + 1));
    endfunction

    task automatic note_error();
        test_errors++;
    endtask

    // All stimulus changes happen here on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        case (ready_mode)
            READY_RANDOM: m_ready = rand_bits(1);
            READY_LOW:    m_ready = 1'b0;
            default:      m_ready = 1'b1;
        endcase
    endtask

    task automatic drive_phy(input logic [7:0] d, input logic dv, input logic er);
        next_cycle();
        phy_in.data = d;
        phy_in.dv   = dv;
        phy_in.er   = er;
    endtask

    // Random body of len-4 bytes, then the FCS sent low byte first
    task automatic build_frame(input int len);
        logic [31:0] crc;
        logic [7:0]  b;
        frame_q.delete();
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len - 4; i++) begin
            b = rand_bits(8);
            frame_q.push_back(b);
            for (int j = 0; j < 8; j++) begin
                crc = (crc >> 1) ^ ((crc[0] ^ b[j]) ? `ETH_CRC_POLY : 32'h0);
            end
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(crc[8*i +: 8]);
        end
    endtask

    // er_idx below zero means a clean frame
    task automatic send_frame(input int er_idx);
        int pre_len;
        int gap;
        pre_len = rand_range(1, 7);
        gap     = rand_range(12, 27);
        repeat (pre_len) drive_phy(8'h55, 1'b1, 1'b0);
        drive_phy(8'hD5, 1'b1, 1'b0);           // SFD
        foreach (frame_q[i]) begin
            drive_phy(frame_q[i], 1'b1, (i == er_idx));
        end
        repeat (gap) drive_phy(8'h00, 1'b0, 1'b0);
    endtask

    // Output carries the body only with the FCS stripped
    task automatic expect_frame();
        for (int i = 0; i < frame_q.size() - 4; i++) begin
            exp_q.push_back({frame_q[i], (i == frame_q.size() - 5)});
        end
        exp_ok++;
    endtask

    task automatic send_good(input int len);
        build_frame(len);
        expect_frame();
        send_frame(-1);
    endtask

    task automatic send_fcs_bad(input int len);
        int pos;
        build_frame(len);
        pos = rand_range(0, len - 1);           // Body or FCS byte
        frame_q[pos] = frame_q[pos] ^ 8'(rand_range(1, 255));
        exp_fcs++;
        send_frame(-1);
    endtask

    task automatic send_phy_err(input int len);
        build_frame(len);
        exp_phy++;
        send_frame(rand_range(0, len - 1));     // FCS stays correct
    endtask

    task automatic send_len_err();
        if (rand_bits(1)) begin
            build_frame(rand_range(20, 63));    // Runt
        end else begin
            build_frame(rand_range(1519, 1530));
        end
        exp_len++;
        send_frame(-1);
    endtask

    task automatic compare_count(input string name, input logic [`ETH_CNT_WIDTH-1:0] got,
                                 input int want);
        assert (got == `ETH_CNT_WIDTH'(want)) else begin
            $display("Mismatch at %0t: %s is %0d, model has %0d", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic check_stats();
        compare_count("frames_ok", stats.frames_ok, exp_ok);
        compare_count("frames_fcs_err", stats.frames_fcs_err, exp_fcs);
        compare_count("frames_phy_err", stats.frames_phy_err, exp_phy);
        compare_count("frames_len_err", stats.frames_len_err, exp_len);
        compare_count("frames_overflow", stats.frames_overflow, exp_ovf);
    endtask

    // Drain with ready high, then settle and report the test
    task automatic finish_test(input string name);
        int waited;
        ready_mode = READY_HIGH;
        waited     = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Error at %0t: %0d expected bytes never came out", $time, exp_q.size());
            note_error();
        end
        exp_q.delete();
        repeat (20) next_cycle();               // Catch stray bytes
        check_stats();
        tests_run++;
        if (test_errors == 0) begin
            tests_ok++;
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        total_errors += test_errors;
        test_errors   = 0;
    endtask

    // Output monitor sampling pre-edge values at the transfer edge
    always @(posedge clk) begin
        if (reset_n && stall_q) begin
            assert (m_valid && (m_axis == held_q)) else begin
                $display("Error at %0t: output changed while held by m_ready low", $time);
                note_error();
            end
        end
        if (reset_n && m_valid && m_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Error at %0t: byte %02h came out with no frame expected",
                         $time, m_axis.data);
                note_error();
            end
            if (exp_q.size() != 0) begin
                exp_byte = exp_q.pop_front();
                assert ({m_axis.data, m_axis.last} == exp_byte) else begin
                    $display("Mismatch at %0t: got data %02h last %0b, want data %02h last %0b",
                             $time, m_axis.data, m_axis.last, exp_byte[8:1], exp_byte[0]);
                    note_error();
                end
            end
        end
        stall_q = reset_n && m_valid && !m_ready;
        held_q  = m_axis;
    end

    // Watchdog sized from the worst-case frame traffic
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t: the tests did not finish in time", $time);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int  free_bytes;
        int  len;
        bit  done;
        phy_in       = '0;
        m_ready      = 1'b0;
        ready_mode   = READY_HIGH;
        lfsr_q       = 16'd31374;
        stall_q      = 1'b0;
        held_q       = '0;
        exp_ok       = 0;
        exp_fcs      = 0;
        exp_phy      = 0;
        exp_len      = 0;
        exp_ovf      = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_ok     = 0;
        wait (reset_n);
        next_cycle();
        assert (!m_valid && (stats == '0)) else begin
            $display("Error at %0t: outputs not cleared by reset", $time);
            note_error();
        end

        repeat (12) send_good(rand_range(64, 1518));
        finish_test("good frames");

        repeat (6) send_fcs_bad(rand_range(64, 512));
        send_good(rand_range(64, 128));         // Store still works after rollbacks
        finish_test("FCS errors");

        repeat (6) send_phy_err(rand_range(64, 512));
        finish_test("PHY errors");

        repeat (8) send_len_err();
        finish_test("length errors");

        ready_mode = READY_RANDOM;
        repeat (16) begin
            case (rand_range(0, 3))
                0:       send_fcs_bad(rand_range(64, 400));
                1:       send_phy_err(rand_range(64, 400));
                2:       send_len_err();
                default: send_good(rand_range(64, 400));
            endcase
        end
        finish_test("mixed traffic with back-pressure");

        ready_mode = READY_LOW;
        free_bytes = `ETH_FIFO_DEPTH;           // Store is empty after the last drain
        done       = 1'b0;
        while (!done) begin
            len = rand_range(64, 1518);
            build_frame(len);
            if (len - 4 <= free_bytes) begin
                expect_frame();
                free_bytes -= len - 4;
            end else begin
                exp_ovf++;                      // Does not fit and gets rolled back
                done = 1'b1;
            end
            send_frame(-1);
        end
        finish_test("overflow");

        $display("Tests: %0d run, %0d ok, %0d bad, %0d errors",
                 tests_run, tests_ok, tests_run - tests_ok, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 4,             // Clock period in ns
    parameter int RESET_CYCLES = 8              // Rising edges with reset held low
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                         // Release away from the sampling edge
        reset_n = 1'b1;
    end

endmodule

// File: verilog/eth_rx_top.sv
`timescale 1ns/10ps

module eth_rx_top import eth_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  phy_rx_t    phy_in,                  // GMII receive side
    output axis_byte_t m_axis,                  // Accepted frames, FCS removed
    output logic       m_valid,
    input  logic       m_ready,
    output rx_stats_t  stats                    // Frame counters by cause
);

    mac_beat_t mac_beat;                        // MAC beats toward the frame store
    logic      mac_valid;

    // Preamble strip, CRC and length checks
    rx_mac u_rx_mac (
        .clk       (clk),
        .reset_n   (reset_n),
        .phy_in    (phy_in),
        .mac_beat  (mac_beat),
        .mac_valid (mac_valid)
    );

    // Store and forward with rollback of bad frames
    rx_frame_fifo u_rx_frame_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .mac_beat  (mac_beat),
        .mac_valid (mac_valid),
        .m_axis    (m_axis),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .stats     (stats)
    );

endmodule

// File: verilog/rx_frame_fifo.sv
`timescale 1ns/10ps

`include "eth_settings.svh"

module rx_frame_fifo import eth_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  mac_beat_t  mac_beat,                // Beats from the MAC, no back-pressure
    input  logic       mac_valid,
    output axis_byte_t m_axis,                  // Committed frames only
    output logic       m_valid,
    input  logic       m_ready,
    output rx_stats_t  stats
);

    localparam int DEPTH = `ETH_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    axis_byte_t  mem [DEPTH];                   // Byte plus last flag per entry
    logic [AW:0] wr_commit_q;                   // End of the last good frame
    logic [AW:0] wr_spec_q;                     // Write point of the frame in flight
    logic [AW:0] rd_q;
    logic [AW:0] wr_spec_inc;
    logic [AW:0] level;                         // Entries in use, including the open frame
    logic        full;
    logic        discard_q;                     // Open frame ran out of room
    logic        beat_wr;
    logic        rd_fire;
    axis_byte_t  wr_byte;

    assign level       = wr_spec_q - rd_q;
    assign full        = level[AW];             // level == DEPTH
    assign wr_spec_inc = wr_spec_q + 1'b1;
    assign beat_wr     = mac_valid && !discard_q && !full;

    assign wr_byte.data = mac_beat.data;
    assign wr_byte.last = mac_beat.last;

    // Reader sees only the committed region
    assign m_valid = (rd_q != wr_commit_q);
    assign m_axis  = mem[rd_q[AW-1:0]];         // Held until the byte is taken
    assign rd_fire = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if (beat_wr) begin
            mem[wr_spec_q[AW-1:0]] <= wr_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_commit_q <= '0;
            wr_spec_q   <= '0;
            rd_q        <= '0;
            discard_q   <= 1'b0;
            stats       <= '0;
        end else begin
            if (rd_fire) begin
                rd_q <= rd_q + 1'b1;
            end

            if (mac_valid) begin
                if (!beat_wr) begin
                    // No room, drop everything up to the closing beat
                    if (mac_beat.last) begin
                        wr_spec_q             <= wr_commit_q;
                        discard_q             <= 1'b0;
                        stats.frames_overflow <= stats.frames_overflow + 1'b1;
                    end else begin
                        discard_q <= 1'b1;
                    end
                end else if (!mac_beat.last) begin
                    wr_spec_q <= wr_spec_inc;
                end else if (mac_beat.status == RX_OK) begin
                    wr_spec_q       <= wr_spec_inc;
                    wr_commit_q     <= wr_spec_inc; // Frame becomes readable next cycle
                    stats.frames_ok <= stats.frames_ok + 1'b1;
                end else begin
                    wr_spec_q <= wr_commit_q;   // Rewind over the bad frame
                    case (mac_beat.status)
                        RX_FCS_ERR: begin
                            stats.frames_fcs_err <= stats.frames_fcs_err + 1'b1;
                        end
                        RX_PHY_ERR: begin
                            stats.frames_phy_err <= stats.frames_phy_err + 1'b1;
                        end
                        RX_LEN_ERR: begin
                            stats.frames_len_err <= stats.frames_len_err + 1'b1;
                        end
                        default: begin
                            stats.frames_overflow <= stats.frames_overflow + 1'b1;
                        end
                    endcase
                end
            end
        end
    end

endmodule
